// File: hw/rv32_core_pkg.sv
`default_nettype none

package rv32_core_pkg;

    //======================================================================
    // Datapath widths
    //======================================================================

    localparam int xlen = 32;

    // One data word and one register index
    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // Byte address held by the program counter
    typedef logic [31:0] pc_t;

    // Instruction memory, word addressed
    localparam int imem_depth = 64;
    typedef logic [$clog2(imem_depth)-1:0] imem_addr_t;

    //======================================================================
    // ALU operations
    //======================================================================

    // pass_b forwards operand b untouched, used by LUI
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b
    } alu_op_t;

endpackage

`default_nettype wire

// File: hw/rv32_isa_pkg.sv
`default_nettype none

package rv32_isa_pkg;

    //======================================================================
    // Opcodes
    //======================================================================

    // Only the integer ALU groups and LUI are decoded
    // Any other opcode value is treated as a NOP
    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } opcode_t;

    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // funct3 codes shared by the R-type and I-type ALU groups
    localparam funct3_t f3_add_sub = 3'b000;
    localparam funct3_t f3_sll     = 3'b001;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_sltu    = 3'b011;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_srl_sra = 3'b101;
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;

    // Selects SUB over ADD and SRA over SRL
    localparam funct7_t f7_alt = 7'b0100000;

    //======================================================================
    // Instruction formats
    //======================================================================

    // R-format, register to register
    typedef struct packed {
        funct7_t    funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_t    funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_fmt_t;

    // I-format, register and 12 bit immediate
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        funct3_t     funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_fmt_t;

    // Same 32 bit word seen through either format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    // ADDI x0,x0,0
    localparam logic [31:0] nop_word = 32'h0000_0013;

endpackage

`default_nettype wire

// File: hw/rv32_regfile.sv
`default_nettype none

module rv32_regfile (
    input  logic                     clk,
    input  rv32_core_pkg::reg_addr_t ra1,
    input  rv32_core_pkg::reg_addr_t ra2,
    output rv32_core_pkg::word_t     rd1,
    output rv32_core_pkg::word_t     rd2,
    input  logic                     wen,
    input  rv32_core_pkg::reg_addr_t wa,
    input  rv32_core_pkg::word_t     wd
);

    import rv32_core_pkg::*;

    // 32 general purpose registers, entry 0 never written
    word_t regs [32];

    //======================================================================
    // Write port
    //======================================================================

    always_ff @(posedge clk) begin
        if (wen && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    //======================================================================
    // Read ports
    //======================================================================

    // x0 is hardwired to zero
    // No write-through, a write becomes visible the cycle after
    assign rd1 = (ra1 == '0) ? word_t'(0) : regs[ra1];
    assign rd2 = (ra2 == '0) ? word_t'(0) : regs[ra2];

endmodule

`default_nettype wire

// File: hw/rv32_fetch.sv
`default_nettype none

module rv32_fetch (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     prog,
    input  logic                     imem_w_en,
    input  rv32_core_pkg::imem_addr_t imem_addr,
    input  rv32_core_pkg::word_t     imem_data,
    output rv32_core_pkg::word_t     instr
);

    import rv32_core_pkg::*;
    import rv32_isa_pkg::*;

    // Instruction storage, loaded from outside while prog is high
    word_t      imem [imem_depth];

    pc_t        pc;
    imem_addr_t pc_idx;
    word_t      instr_q;
    logic       fetch_valid;

    // Word index of the current PC
    assign pc_idx = pc[$bits(imem_addr_t)+1:2];

    // External load port
    always_ff @(posedge clk) begin
        if (prog && imem_w_en) begin
            imem[imem_addr] <= imem_data;
        end
    end

    // Registered read, instruction for PC p shows up one cycle later
    always_ff @(posedge clk) begin
        instr_q <= imem[pc_idx];
    end

    //======================================================================
    // Program counter
    //======================================================================

    always_ff @(posedge clk) begin
        if (reset || prog) begin
            pc          <= '0;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= 1'b1;
            // Wrap back to 0 after the last memory word
            if (pc_idx == imem_addr_t'(imem_depth - 1)) begin
                pc <= '0;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    // NOP while loading, and while read data is not yet valid
    // right after reset or program release
    assign instr = (fetch_valid && !prog) ? instr_q : nop_word;

endmodule

`default_nettype wire

// File: hw/rv32_decode.sv
`default_nettype none

module rv32_decode (
    input  logic                     clk,
    input  logic                     reset,
    input  rv32_core_pkg::word_t     instr,
    output rv32_core_pkg::reg_addr_t ra1,
    output rv32_core_pkg::reg_addr_t ra2,
    input  rv32_core_pkg::word_t     rd1,
    input  rv32_core_pkg::word_t     rd2,
    output rv32_core_pkg::alu_op_t   ex_op,
    output rv32_core_pkg::word_t     ex_a,
    output rv32_core_pkg::word_t     ex_b,
    output rv32_core_pkg::reg_addr_t ex_rd,
    output logic                     ex_write
);

    import rv32_core_pkg::*;
    import rv32_isa_pkg::*;

    instr_u  iw;
    alu_op_t dec_op;
    word_t   dec_b;
    logic    dec_known;
    logic    dec_nop;
    logic    dec_write;

    // Map funct3 plus the alternate bit to an ALU operation
    // SUB only exists in the register group
    function automatic alu_op_t funct_op(funct3_t f3, logic alt, logic is_reg);
        case (f3)
            f3_add_sub: funct_op = (alt && is_reg) ? alu_sub : alu_add;
            f3_sll:     funct_op = alu_sll;
            f3_slt:     funct_op = alu_slt;
            f3_sltu:    funct_op = alu_sltu;
            f3_xor:     funct_op = alu_xor;
            f3_srl_sra: funct_op = alt ? alu_sra : alu_srl;
            f3_or:      funct_op = alu_or;
            default:    funct_op = alu_and;
        endcase
    endfunction

    assign iw = instr;

    // Register reads straight from the word, data returns this cycle
    assign ra1 = iw.r.rs1;
    assign ra2 = iw.r.rs2;

    //======================================================================
    // Operation and operand b
    //======================================================================

    always_comb begin
        dec_op    = alu_add;
        dec_b     = rd2;
        dec_known = 1'b1;
        case (iw.r.opcode)
            op_reg: begin
                dec_op = funct_op(iw.r.funct3, iw.r.funct7 == f7_alt, 1'b1);
            end
            op_imm: begin
                dec_op = funct_op(iw.i.funct3, iw.i.imm12[11:5] == f7_alt, 1'b0);
                // Shift amount lives in the low 5 immediate bits
                if ((iw.i.funct3 == f3_sll) || (iw.i.funct3 == f3_srl_sra)) begin
                    dec_b = {{(xlen-5){1'b0}}, iw.i.imm12[4:0]};
                end else begin
                    dec_b = {{(xlen-12){iw.i.imm12[11]}}, iw.i.imm12};
                end
            end
            op_lui: begin
                dec_op = alu_pass_b;
                dec_b  = {instr[31:12], 12'b0};
            end
            default: dec_known = 1'b0;
        endcase
    end

    // Canonical NOP and anything undecoded write nothing
    assign dec_nop   = (instr == nop_word) || !dec_known;
    assign dec_write = !dec_nop;

    //======================================================================
    // Decode to execute register
    //======================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_write <= 1'b0;
        end else begin
            ex_write <= dec_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_op <= dec_op;
        ex_a  <= rd1;
        ex_b  <= dec_b;
        ex_rd <= iw.r.rd;
    end

endmodule

`default_nettype wire

// File: hw/rv32_execute.sv
`default_nettype none

module rv32_execute (
    input  logic                     clk,
    input  logic                     reset,
    input  rv32_core_pkg::alu_op_t   ex_op,
    input  rv32_core_pkg::word_t     ex_a,
    input  rv32_core_pkg::word_t     ex_b,
    input  rv32_core_pkg::reg_addr_t ex_rd,
    input  logic                     ex_write,
    output rv32_core_pkg::word_t     wb_result,
    output rv32_core_pkg::reg_addr_t wb_rd,
    output logic                     wb_write
);

    import rv32_core_pkg::*;

    word_t      alu_res;
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // Shifts only look at the low 5 bits of b
    assign shamt = ex_b[4:0];

    // Compare results for SLT and SLTU
    assign lt_signed   = $signed(ex_a) < $signed(ex_b);
    assign lt_unsigned = ex_a < ex_b;

    //======================================================================
    // ALU
    //======================================================================

    always_comb begin
        case (ex_op)
            alu_add:    alu_res = ex_a + ex_b;
            alu_sub:    alu_res = ex_a - ex_b;
            alu_and:    alu_res = ex_a & ex_b;
            alu_or:     alu_res = ex_a | ex_b;
            alu_xor:    alu_res = ex_a ^ ex_b;
            alu_sll:    alu_res = ex_a << shamt;
            alu_srl:    alu_res = ex_a >> shamt;
            // Arithmetic shift keeps the sign bit
            alu_sra:    alu_res = word_t'($signed(ex_a) >>> shamt);
            alu_slt:    alu_res = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:   alu_res = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_pass_b: alu_res = ex_b;
            default:    alu_res = '0;
        endcase
    end

    //======================================================================
    // Execute to write-back register
    //======================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_write <= 1'b0;
        end else begin
            wb_write <= ex_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_result <= alu_res;
        wb_rd     <= ex_rd;
    end

endmodule

`default_nettype wire

// File: hw/rv32_writeback.sv
`default_nettype none

module rv32_writeback (
    input  logic                     clk,
    input  logic                     reset,
    input  rv32_core_pkg::word_t     wb_result,
    input  rv32_core_pkg::reg_addr_t wb_rd,
    input  logic                     wb_write,
    output logic                     rf_wen,
    output rv32_core_pkg::reg_addr_t rf_wa,
    output rv32_core_pkg::word_t     rf_wd,
    output logic                     retire_valid,
    output rv32_core_pkg::reg_addr_t retire_rd,
    output rv32_core_pkg::word_t     retire_data
);

    import rv32_core_pkg::*;

    // Register file write comes straight from the stage register
    assign rf_wen = wb_write;
    assign rf_wa  = wb_rd;
    assign rf_wd  = wb_result;

    //======================================================================
    // Retire port
    //======================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= wb_write;
        end
    end

    // x0 keeps zero, so report what the register file really holds
    always_ff @(posedge clk) begin
        retire_rd   <= wb_rd;
        retire_data <= (wb_rd == '0) ? word_t'(0) : wb_result;
    end

endmodule

`default_nettype wire

// File: hw/rv32_core.sv
`default_nettype none

module rv32_core (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      prog,
    input  logic                      imem_w_en,
    input  rv32_core_pkg::imem_addr_t imem_addr,
    input  rv32_core_pkg::word_t      imem_data,
    output logic                      retire_valid,
    output rv32_core_pkg::reg_addr_t  retire_rd,
    output rv32_core_pkg::word_t      retire_data
);

    import rv32_core_pkg::*;

    //======================================================================
    // Stage wires
    //======================================================================

    // Fetch to decode
    word_t     instr;

    // Register file ports
    reg_addr_t ra1;
    reg_addr_t ra2;
    word_t     rd1;
    word_t     rd2;
    logic      rf_wen;
    reg_addr_t rf_wa;
    word_t     rf_wd;

    // Decode to execute
    alu_op_t   ex_op;
    word_t     ex_a;
    word_t     ex_b;
    reg_addr_t ex_rd;
    logic      ex_write;

    // Execute to write-back
    word_t     wb_result;
    reg_addr_t wb_rd;
    logic      wb_write;

    //======================================================================
    // Stages
    //======================================================================

    rv32_fetch u_fetch (
        .clk(clk), .reset(reset), .prog(prog),
        .imem_w_en(imem_w_en), .imem_addr(imem_addr), .imem_data(imem_data),
        .instr(instr)
    );

    rv32_regfile u_regfile (
        .clk(clk), .ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2),
        .wen(rf_wen), .wa(rf_wa), .wd(rf_wd)
    );

    rv32_decode u_decode (
        .clk(clk), .reset(reset), .instr(instr),
        .ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2),
        .ex_op(ex_op), .ex_a(ex_a), .ex_b(ex_b), .ex_rd(ex_rd), .ex_write(ex_write)
    );

    rv32_execute u_execute (
        .clk(clk), .reset(reset),
        .ex_op(ex_op), .ex_a(ex_a), .ex_b(ex_b), .ex_rd(ex_rd), .ex_write(ex_write),
        .wb_result(wb_result), .wb_rd(wb_rd), .wb_write(wb_write)
    );

    // Register file write and retire report leave from here
    rv32_writeback u_writeback (
        .clk(clk), .reset(reset),
        .wb_result(wb_result), .wb_rd(wb_rd), .wb_write(wb_write),
        .rf_wen(rf_wen), .rf_wa(rf_wa), .rf_wd(rf_wd),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data)
    );

endmodule

`default_nettype wire

// File: bench/rv32_core_sva.sv
`default_nettype none

module rv32_core_sva (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     prog,
    input  logic                     retire_valid,
    input  rv32_core_pkg::reg_addr_t retire_rd
);

    timeunit 1ns;
    timeprecision 100ps;

    // Number of assertion failures, read by the testbench
    int fail_count = 0;

    //======================================================================
    // Retire port rules
    //======================================================================

    // A reset edge leaves the retire port quiet
    a_reset_quiet: assert property (@(posedge clk) reset |=> !retire_valid)
    else begin
        fail_count++;
        $error("retire_valid high after a reset cycle");
    end

    // Fetch emits NOP while loading, nothing can retire
    a_prog_quiet: assert property (@(posedge clk) disable iff (reset)
        prog |-> !retire_valid)
    else begin
        fail_count++;
        $error("retire_valid high while program is high");
    end

    // First real instruction needs 3 more cycles to reach retire
    a_release_gap: assert property (@(posedge clk) disable iff (reset)
        $fell(prog) |-> !retire_valid ##1 !retire_valid ##1 !retire_valid)
    else begin
        fail_count++;
        $error("retire_valid high too soon after program fell");
    end

    a_rd_known: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> !$isunknown(retire_rd))
    else begin
        fail_count++;
        $error("retire_rd unknown during a retire pulse");
    end

endmodule

bind rv32_core rv32_core_sva u_sva (
    .clk(clk), .reset(reset), .prog(prog),
    .retire_valid(retire_valid), .retire_rd(retire_rd)
);

`default_nettype wire

// File: bench/rv32_core_tb.sv
`default_nettype none

module rv32_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rv32_core_pkg::*;
    import rv32_isa_pkg::*;

    // Kind of table entry, bad is an opcode the core does not decode
    typedef enum logic [2:0] {k_reg, k_imm, k_lui, k_nop, k_bad} kind_t;

    // One program instruction plus its expected retire
    typedef struct {
        kind_t     kind;
        alu_op_t   op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     imm;
        logic      exp_retire;
        word_t     exp_data;
    } entry_t;

    logic       clk = 1'b0;
    logic       reset;
    logic       prog_en;
    logic       imem_w_en;
    imem_addr_t imem_addr;
    word_t      imem_data;
    logic       retire_valid;
    reg_addr_t  retire_rd;
    word_t      retire_data;

    // Two program tables, the second one is loaded over the first
    entry_t tab [2][imem_depth];
    int     tab_len [2];
    word_t  model_regs [32];
    word_t  rng_state = 32'd98;
    logic   tables_ready = 1'b0;

    alu_op_t r_ops [10] = '{alu_add, alu_sub, alu_and, alu_or, alu_xor,
                            alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu};
    alu_op_t i_ops [9]  = '{alu_add, alu_slt, alu_sltu, alu_xor, alu_or,
                            alu_and, alu_sll, alu_srl, alu_sra};

    always #5 clk = ~clk;

    rv32_core DUT (
        .clk(clk), .reset(reset), .prog(prog_en),
        .imem_w_en(imem_w_en), .imem_addr(imem_addr), .imem_data(imem_data),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data)
    );

    //======================================================================
    // Stimulus generation
    //======================================================================

    function automatic word_t xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Sources come from the seeded x1..x8, results land in x9..x31
    function automatic int pick_src();
        return 1 + int'(xorshift32() % 8);
    endfunction

    function automatic int pick_dst();
        return 9 + int'(xorshift32() % 23);
    endfunction

    task automatic add_entry(int p, kind_t kind, alu_op_t op, int rd, int rs1, int rs2,
                             word_t imm);
        entry_t e;
        e.kind = kind;
        e.op = op;
        e.rd = reg_addr_t'(rd);
        e.rs1 = reg_addr_t'(rs1);
        e.rs2 = reg_addr_t'(rs2);
        e.imm = imm;
        e.exp_retire = 1'b0;
        e.exp_data = '0;
        tab[p][tab_len[p]] = e;
        tab_len[p]++;
    endtask

    task automatic build_program(int p);
        int r;
        int k;
        tab_len[p] = 0;
        // Seed registers, each ADDI is 8 slots after its LUI
        for (r = 1; r <= 8; r++) begin
            add_entry(p, k_lui, alu_pass_b, r, 0, 0, xorshift32());
        end
        for (r = 1; r <= 8; r++) begin
            add_entry(p, k_imm, alu_add, r, r, 0, xorshift32());
        end
        // Gap so the last seed is written before any read
        add_entry(p, k_nop, alu_add, 0, 0, 0, '0);
        add_entry(p, k_bad, alu_add, 0, 0, 0, 32'h0000_0073);
        add_entry(p, k_nop, alu_add, 0, 0, 0, '0);
        add_entry(p, k_bad, alu_add, 0, 0, 0, 32'h0020_a023);
        // Second program runs the op lists backwards
        for (k = 0; k < 10; k++) begin
            add_entry(p, k_reg, r_ops[(p == 0) ? k : 9 - k], pick_dst(), pick_src(),
                      pick_src(), '0);
        end
        for (k = 0; k < 9; k++) begin
            add_entry(p, k_imm, i_ops[(p == 0) ? k : 8 - k], pick_dst(), pick_src(), 0,
                      xorshift32());
        end
        add_entry(p, k_lui, alu_pass_b, pick_dst(), 0, 0, xorshift32());
        // Write to x0, a gap of NOP, FENCE.I and ECALL, then two reads of x0
        add_entry(p, k_imm, alu_add, 0, pick_src(), 0, xorshift32());
        add_entry(p, k_nop, alu_add, 0, 0, 0, '0);
        add_entry(p, k_bad, alu_add, 0, 0, 0, 32'h0000_100f);
        add_entry(p, k_nop, alu_add, 0, 0, 0, '0);
        add_entry(p, k_bad, alu_add, 0, 0, 0, 32'h0000_0073);
        add_entry(p, k_reg, alu_add, pick_dst(), 0, pick_src(), '0);
        add_entry(p, k_imm, alu_or, pick_dst(), 0, 0, xorshift32());
    endtask

    function automatic funct3_t op_funct3(alu_op_t op);
        case (op)
            alu_sll:          return f3_sll;
            alu_slt:          return f3_slt;
            alu_sltu:         return f3_sltu;
            alu_xor:          return f3_xor;
            alu_srl, alu_sra: return f3_srl_sra;
            alu_or:           return f3_or;
            alu_and:          return f3_and;
            default:          return f3_add_sub;
        endcase
    endfunction

    // Machine word for one entry, per the RV32I encoding
    function automatic word_t encode(entry_t e);
        r_fmt_t      r;
        i_fmt_t      i;
        funct7_t     f7;
        logic [11:0] imm12;
        f7 = ((e.op == alu_sub) || (e.op == alu_sra)) ? f7_alt : 7'b0;
        // Shift immediates carry funct7 above a 5 bit amount
        if (e.op inside {alu_sll, alu_srl, alu_sra}) begin
            imm12 = {f7, e.imm[4:0]};
        end else begin
            imm12 = e.imm[11:0];
        end
        r = '{f7, e.rs2, e.rs1, op_funct3(e.op), e.rd, op_reg};
        i = '{imm12, e.rs1, op_funct3(e.op), e.rd, op_imm};
        case (e.kind)
            k_reg:   return r;
            k_imm:   return i;
            k_lui:   return {e.imm[19:0], e.rd, op_lui};
            k_bad:   return e.imm;
            default: return nop_word;
        endcase
    endfunction

    //======================================================================
    // Reference model
    //======================================================================

    function automatic word_t ref_alu(alu_op_t op, word_t a, word_t b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return word_t'($signed(a) >>> b[4:0]);
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            default:  return b;
        endcase
    endfunction

    // Walk the table in order and fill in the expected retires
    task automatic model_program(int p);
        int     i;
        entry_t e;
        word_t  b;
        word_t  res;
        for (i = 0; i < tab_len[p]; i++) begin
            e = tab[p][i];
            res = '0;
            e.exp_retire = 1'b1;
            case (e.kind)
                k_reg: res = ref_alu(e.op, model_regs[e.rs1], model_regs[e.rs2]);
                k_imm: begin
                    if (e.op inside {alu_sll, alu_srl, alu_sra}) begin
                        b = {27'b0, e.imm[4:0]};
                    end else begin
                        b = {{20{e.imm[11]}}, e.imm[11:0]};
                    end
                    res = ref_alu(e.op, model_regs[e.rs1], b);
                end
                k_lui: res = {e.imm[19:0], 12'b0};
                default: e.exp_retire = 1'b0;
            endcase
            // x0 holds zero whatever was computed
            if (e.rd == '0) begin
                res = '0;
            end
            if (e.exp_retire) begin
                model_regs[e.rd] = res;
            end
            e.exp_data = res;
            tab[p][i] = e;
        end
    endtask

    //======================================================================
    // Checks
    //======================================================================

    task automatic stop_run(string why);
        if (why != "") begin
            $display("ERROR: %s", why);
        end
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            stop_run("");
        end
    endtask

    task automatic check_reg_addr(string name, reg_addr_t exp, reg_addr_t act);
        if (act !== exp) begin
            $display("FAILED %s expected x%0d actual x%0d", name, exp, act);
            stop_run("");
        end
    endtask

    // Bound checker failures end the run as soon as they are counted
    always @(DUT.u_sva.fail_count) begin
        if (DUT.u_sva.fail_count != 0) begin
            stop_run("an assertion on the retire port failed");
        end
    end

    // Retire outputs are sampled on the falling edge
    task automatic wait_retire();
        @(negedge clk);
        while (retire_valid !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic run_program(int p);
        int      a;
        int      i;
        alu_op_t op;
        string   name;
        // Load the whole memory under program, NOP padding past the table
        @(posedge clk);
        #1;
        prog_en = 1'b1;
        for (a = 0; a < imem_depth; a++) begin
            @(posedge clk);
            #1;
            imem_w_en = 1'b1;
            imem_addr = imem_addr_t'(a);
            imem_data = (a < tab_len[p]) ? encode(tab[p][a]) : nop_word;
        end
        @(posedge clk);
        #1;
        imem_w_en = 1'b0;
        prog_en = 1'b0;
        // Retires in program order, NOPs and unknown opcodes skipped
        for (i = 0; i < tab_len[p]; i++) begin
            if (tab[p][i].exp_retire) begin
                wait_retire();
                op = tab[p][i].op;
                name = $sformatf("prog%0d entry %0d %s", p, i, op.name());
                check_reg_addr({name, " rd"}, tab[p][i].rd, retire_rd);
                check_word({name, " data"}, tab[p][i].exp_data, retire_data);
            end
        end
        repeat (6) begin
            @(negedge clk);
            if (retire_valid !== 1'b0) begin
                stop_run("retire pulse seen while only NOP padding was running");
            end
        end
    endtask

    //======================================================================
    // Main sequence and watchdog
    //======================================================================

    initial begin
        int r;
        reset = 1'b1;
        prog_en = 1'b1;
        imem_w_en = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        for (r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        build_program(0);
        model_program(0);
        build_program(1);
        model_program(1);
        tables_ready = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        run_program(0);
        // Reload restarts from address 0 with the second table
        run_program(1);
        if (DUT.u_sva.fail_count != 0) begin
            stop_run("assertion failures were reported on the retire port");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    // Each run needs a load, its table, a memory sweep and some margin
    initial begin
        int limit;
        wait (tables_ready);
        limit = 8 + 2 * (2 * imem_depth + 20) + tab_len[0] + tab_len[1];
        repeat (limit) @(posedge clk);
        stop_run("watchdog expired before all expected retire pulses arrived");
    end

endmodule

`default_nettype wire

// File: build.f
hw/rv32_core_pkg.sv
hw/rv32_isa_pkg.sv
hw/rv32_regfile.sv
hw/rv32_fetch.sv
hw/rv32_decode.sv
hw/rv32_execute.sv
hw/rv32_writeback.sv
hw/rv32_core.sv
bench/rv32_core_sva.sv
bench/rv32_core_tb.sv
